// File: cad.f
source/cad_pkg.sv
source/mat_sram.sv
source/cad_ctrl.sv
source/sram_addr_gen.sv
source/conv_mac.sv
source/max_pool_ser.sv
source/cad_top.sv
bench/cad_tb.sv

// File: Makefile
TOP = cad_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f cad.f -Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee sim.log
	@if grep -q "Finished with errors" sim.log; then exit 1; fi
	@grep -q "Finished with no errors" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module cad_top -f cad.f

clean:
	rm -rf obj_dir sim.log

// File: bench/cad_tb.sv
`default_nettype none

module cad_tb;

    import cad_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int IDLE_GAP = 8;
    localparam int MAX_WORDS = 1024;

    // rough cycle cost of one load and one request
    function automatic int load_cycles(input int code);
        int side;
        side = 8 << code;
        return NUM_MATS * side * side + KER_DEPTH + IDLE_GAP;
    endfunction

    function automatic int req_cycles(input int code);
        int p;
        p = ((8 << code) - 4) / 2;
        // four windows of 25 taps per pooled value
        return 4 * KER_TAPS * p * p + 40 + IDLE_GAP;
    endfunction

    localparam int CYCLE_LIMIT = 2 * (RESET_CYCLES + 4
        + load_cycles(0) + 4 * req_cycles(0)
        + load_cycles(1) + 2 * req_cycles(1)
        + load_cycles(2) + 2 * req_cycles(2));

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     in_valid;
    logic                     in_valid2;
    logic signed [DATA_W-1:0] matrix;
    logic [SIZE_W-1:0]        matrix_size;
    logic [IDX_W-1:0]         matrix_idx;
    logic                     out_valid;
    logic                     out_value;

    // copies of everything loaded
    logic signed [DATA_W-1:0] img_ref [0:IMG_DEPTH-1];
    logic signed [DATA_W-1:0] ker_ref [0:KER_DEPTH-1];
    int                       cur_side = 8;
    // expected words of the whole run, in order
    logic [ACC_W-1:0]         exp_mem [0:MAX_WORDS-1];
    int                       exp_count = 0;
    logic                     req_sent;
    // output monitor
    int                       cycle_cnt = 0;
    logic                     out_valid_q;
    int                       burst_len;
    logic [ACC_W-1:0]         shift_word;
    int                       word_idx;

    always #2 clk = ~clk;

    cad_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_valid2   (in_valid2),
        .matrix      (matrix),
        .matrix_size (matrix_size),
        .matrix_idx  (matrix_idx),
        .out_valid   (out_valid),
        .out_value   (out_value)
    );

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    // ##############################
    // stimulus and model
    // ##############################
    task automatic load_mats(input int code, input bit extreme);
        int side;
        int n_img;
        int i;
        logic [DATA_W-1:0] b;
        side = 8 << code;
        n_img = side * side;
        cur_side = side;
        // image 15 all -128 when extreme
        for (i = 0; i < NUM_MATS * n_img; i++) begin
            b = DATA_W'($urandom);
            if (extreme && i >= (NUM_MATS - 1) * n_img) begin
                b = 8'h80;
            end
            img_ref[i] = b;
            @(posedge clk);
            in_valid    <= 1'b1;
            matrix_size <= SIZE_W'(code);
            matrix      <= b;
        end
        // kernel 15 all 127 when extreme
        for (i = 0; i < KER_DEPTH; i++) begin
            b = DATA_W'($urandom);
            if (extreme && i >= KER_DEPTH - KER_TAPS) begin
                b = 8'h7f;
            end
            ker_ref[i] = b;
            @(posedge clk);
            matrix <= b;
        end
        @(posedge clk);
        in_valid <= 1'b0;
        matrix   <= '0;
        repeat (3) @(posedge clk);
    endtask

    // valid 5x5 convolution, then 2x2 max, stride 2, row-major
    task automatic push_expected(input int img, input int ker);
        int p;
        int pr;
        int pc;
        int q;
        int r;
        int c;
        int i;
        int j;
        int acc;
        int best;
        int base;
        p = (cur_side - 4) / 2;
        base = img * cur_side * cur_side;
        for (pr = 0; pr < p; pr++) begin
            for (pc = 0; pc < p; pc++) begin
                best = 0;
                for (q = 0; q < 4; q++) begin
                    r = 2 * pr + q / 2;
                    c = 2 * pc + q % 2;
                    acc = 0;
                    for (i = 0; i < KER_DIM; i++) begin
                        for (j = 0; j < KER_DIM; j++) begin
                            acc += int'(img_ref[base + (r + i) * cur_side + c + j])
                                * int'(ker_ref[ker * KER_TAPS + i * KER_DIM + j]);
                        end
                    end
                    if (q == 0 || acc > best) begin
                        best = acc;
                    end
                end
                exp_mem[exp_count] = ACC_W'(best);
                exp_count++;
            end
        end
    endtask

    // two-cycle request, then wait for every expected word
    task automatic send_request(input int img, input int ker);
        push_expected(img, ker);
        @(posedge clk);
        req_sent   <= 1'b1;
        in_valid2  <= 1'b1;
        matrix_idx <= IDX_W'(img);
        @(posedge clk);
        matrix_idx <= IDX_W'(ker);
        @(posedge clk);
        in_valid2  <= 1'b0;
        matrix_idx <= '0;
        while (word_idx != exp_count) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    initial begin
        void'($urandom(32'ha6f4563c));
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_valid2   = 1'b0;
        matrix      = '0;
        matrix_size = '0;
        matrix_idx  = '0;
        req_sent    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);
        // side 8, corner indices included
        load_mats(0, 1'b0);
        send_request(0, 0);
        send_request(15, 15);
        send_request(3, 12);
        send_request(15, 0);
        load_mats(1, 1'b0);
        send_request(7, 2);
        send_request(0, 15);
        // side 32, negative extreme first
        load_mats(2, 1'b1);
        send_request(15, 15);
        send_request(4, 9);
        $display("Finished with no errors");
        $finish;
    end

    // ##############################
    // monitor and timeout
    // ##############################
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
            burst_len   <= 0;
            shift_word  <= '0;
            word_idx    <= 0;
        end else begin
            out_valid_q <= out_valid;
            // lsb arrives first, shifts down to bit 0
            if (out_valid) begin
                shift_word <= {out_value, shift_word[ACC_W-1:1]};
                burst_len  <= (out_valid_q ? burst_len : 0) + 1;
            end else if (out_valid_q) begin
                word_idx <= word_idx + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles", cycle_cnt);
            abort_run();
        end
    end

    // ##############################
    // checks
    // ##############################
    quiet_before_request: assert property (@(posedge clk)
        (cycle_cnt != 0 && !req_sent) |-> (!out_valid && !out_value))
    else begin
        $display("Fail out_valid expected 0 got %h, out_value expected 0 got %h",
            $sampled(out_valid), $sampled(out_value));
        abort_run();
    end

    zero_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> !out_value)
    else begin
        $display("Fail out_value expected 0 got %h", $sampled(out_value));
        abort_run();
    end

    no_extra_words: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (word_idx < exp_count))
    else begin
        $display("out_valid went high when no further word was expected");
        abort_run();
    end

    burst_not_long: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && out_valid_q) |-> (burst_len < ACC_W))
    else begin
        $display("Fail out_valid burst length expected %h got %h",
            ACC_W, $sampled(burst_len) + 1);
        abort_run();
    end

    burst_exact: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid_q && !out_valid) |-> (burst_len == ACC_W))
    else begin
        $display("Fail out_valid burst length expected %h got %h",
            ACC_W, $sampled(burst_len));
        abort_run();
    end

    word_matches: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid_q && !out_valid) |-> (shift_word == exp_mem[word_idx]))
    else begin
        $display("Fail out_value word %0d expected %h got %h", $sampled(word_idx),
            exp_mem[$sampled(word_idx)], $sampled(shift_word));
        abort_run();
    end

endmodule

`default_nettype wire

// File: source/cad_top.sv
`default_nettype none

module cad_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              in_valid,
    input  logic                              in_valid2,
    input  logic signed [cad_pkg::DATA_W-1:0] matrix,
    input  logic [cad_pkg::SIZE_W-1:0]        matrix_size,
    input  logic [cad_pkg::IDX_W-1:0]         matrix_idx,
    output logic                              out_valid,
    output logic                              out_value
);

    import cad_pkg::*;

    // controller to address generator
    logic                  load_img;
    logic                  load_ker;
    logic                  scan_start;
    logic                  scan_en;
    logic [SIZE_W-1:0]     size_code;
    logic [IDX_W-1:0]      img_idx;
    logic [IDX_W-1:0]      ker_idx;
    logic                  load_img_last;
    logic                  load_ker_last;
    logic                  scan_done;
    // memory ports
    logic [IMG_ADDR_W-1:0] img_addr;
    logic [KER_ADDR_W-1:0] ker_addr;
    logic                  img_we;
    logic                  ker_we;
    logic [DATA_W-1:0]     img_rdata;
    logic [DATA_W-1:0]     ker_rdata;
    // window flags and sums
    logic                  tap_first;
    logic                  tap_last;
    logic signed [ACC_W-1:0] sum;
    logic                  sum_valid;

    cad_ctrl i_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_valid2     (in_valid2),
        .matrix_size   (matrix_size),
        .matrix_idx    (matrix_idx),
        .load_img_last (load_img_last),
        .load_ker_last (load_ker_last),
        .scan_done     (scan_done),
        .out_valid     (out_valid),
        .load_img      (load_img),
        .load_ker      (load_ker),
        .scan_start    (scan_start),
        .scan_en       (scan_en),
        .size_code     (size_code),
        .img_idx       (img_idx),
        .ker_idx       (ker_idx)
    );

    sram_addr_gen i_addr_gen (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_img      (load_img),
        .load_ker      (load_ker),
        .scan_start    (scan_start),
        .scan_en       (scan_en),
        .in_valid      (in_valid),
        .size_code     (size_code),
        .img_idx       (img_idx),
        .ker_idx       (ker_idx),
        .img_addr      (img_addr),
        .ker_addr      (ker_addr),
        .img_we        (img_we),
        .ker_we        (ker_we),
        .load_img_last (load_img_last),
        .load_ker_last (load_ker_last),
        .tap_first     (tap_first),
        .tap_last      (tap_last),
        .scan_done     (scan_done)
    );

    // ##############################
    // image and kernel memories
    // ##############################
    // both written straight from matrix
    mat_sram #(
        .DEPTH  (IMG_DEPTH),
        .ADDR_W (IMG_ADDR_W),
        .DATA_W (DATA_W)
    ) i_img_mem (
        .clk   (clk),
        .we    (img_we),
        .addr  (img_addr),
        .wdata (matrix),
        .rdata (img_rdata)
    );

    mat_sram #(
        .DEPTH  (KER_DEPTH),
        .ADDR_W (KER_ADDR_W),
        .DATA_W (DATA_W)
    ) i_ker_mem (
        .clk   (clk),
        .we    (ker_we),
        .addr  (ker_addr),
        .wdata (matrix),
        .rdata (ker_rdata)
    );

    conv_mac i_mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .tap_first (tap_first),
        .tap_last  (tap_last),
        .img_data  (img_rdata),
        .ker_data  (ker_rdata),
        .sum       (sum),
        .sum_valid (sum_valid)
    );

    max_pool_ser #(
        .ACC_W (ACC_W)
    ) i_pool (
        .clk       (clk),
        .rst_n     (rst_n),
        .sum_valid (sum_valid),
        .sum       (sum),
        .out_valid (out_valid),
        .out_value (out_value)
    );

endmodule

`default_nettype wire

// File: source/max_pool_ser.sv
`default_nettype none

module max_pool_ser #(
    parameter int ACC_W = cad_pkg::ACC_W
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    sum_valid,
    input  logic signed [ACC_W-1:0] sum,
    output logic                    out_valid,
    output logic                    out_value
);

    localparam int BIT_W = $clog2(ACC_W);

    // position of a sum in its group of four
    logic [1:0]              grp_cnt;
    logic signed [ACC_W-1:0] max_r;
    // running maximum including this sum
    logic signed [ACC_W-1:0] max_nxt;
    // serializer
    logic [ACC_W-1:0]        shreg;
    logic [BIT_W-1:0]        bit_cnt;

    assign max_nxt = (grp_cnt == 2'd0 || sum > max_r) ? sum : max_r;

    // ##############################
    // group count and output state
    // ##############################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grp_cnt   <= '0;
            out_valid <= 1'b0;
            bit_cnt   <= '0;
        end else begin
            if (sum_valid) begin
                grp_cnt <= grp_cnt + 1'b1;
            end
            // fourth sum starts a word
            if (sum_valid && grp_cnt == 2'd3) begin
                out_valid <= 1'b1;
                bit_cnt   <= '0;
            end else if (out_valid) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == BIT_W'(ACC_W - 1)) begin
                    out_valid <= 1'b0;
                end
            end
        end
    end

    // ##############################
    // max and shift register
    // ##############################
    always_ff @(posedge clk) begin
        if (sum_valid) begin
            max_r <= max_nxt;
        end
        // lsb first
        if (sum_valid && grp_cnt == 2'd3) begin
            shreg <= max_nxt;
        end else if (out_valid) begin
            shreg <= shreg >> 1;
        end
    end

    // zero outside a word
    assign out_value = out_valid && shreg[0];

endmodule

`default_nettype wire

// File: source/conv_mac.sv
`default_nettype none

module conv_mac (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             tap_first,
    input  logic                             tap_last,
    input  logic signed [cad_pkg::DATA_W-1:0] img_data,
    input  logic signed [cad_pkg::DATA_W-1:0] ker_data,
    output logic signed [cad_pkg::ACC_W-1:0]  sum,
    output logic                             sum_valid
);

    import cad_pkg::*;

    // flags one cycle late, in step with the memory data
    logic                        first_d;
    logic                        last_d;
    logic signed [2*DATA_W-1:0]  prod;
    logic signed [ACC_W-1:0]     acc;
    logic signed [ACC_W-1:0]     acc_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            first_d   <= 1'b0;
            last_d    <= 1'b0;
            sum_valid <= 1'b0;
        end else begin
            first_d   <= tap_first;
            last_d    <= tap_last;
            sum_valid <= last_d;
        end
    end

    // signed 8 x 8
    assign prod    = img_data * ker_data;
    // restart on the first tap of a window
    assign acc_nxt = (first_d ? ACC_W'(0) : acc) + ACC_W'(prod);

    // ##############################
    // accumulator and result
    // ##############################
    // between windows acc runs free, first tap clears it
    always_ff @(posedge clk) begin
        acc <= acc_nxt;
        if (last_d) begin
            sum <= acc_nxt;
        end
    end

endmodule

`default_nettype wire

// File: source/sram_addr_gen.sv
`default_nettype none

module sram_addr_gen (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           load_img,
    input  logic                           load_ker,
    input  logic                           scan_start,
    input  logic                           scan_en,
    input  logic                           in_valid,
    input  logic [cad_pkg::SIZE_W-1:0]     size_code,
    input  logic [cad_pkg::IDX_W-1:0]      img_idx,
    input  logic [cad_pkg::IDX_W-1:0]      ker_idx,
    output logic [cad_pkg::IMG_ADDR_W-1:0] img_addr,
    output logic [cad_pkg::KER_ADDR_W-1:0] ker_addr,
    output logic                           img_we,
    output logic                           ker_we,
    output logic                           load_img_last,
    output logic                           load_ker_last,
    output logic                           tap_first,
    output logic                           tap_last,
    output logic                           scan_done
);

    import cad_pkg::*;

    // load write counters
    logic [IMG_ADDR_W-1:0] img_wr_addr;
    logic [KER_ADDR_W-1:0] ker_wr_addr;
    logic [IMG_ADDR_W-1:0] img_end;
    // log2 of the side, 3 to 5
    logic [3:0]            side_log;
    // last pooled index, P - 1
    logic [3:0]            p_max;
    // scan counters, innermost first
    logic [2:0]            tap_c;
    logic [2:0]            tap_r;
    logic [1:0]            quad;
    logic [3:0]            pool_c;
    logic [3:0]            pool_r;
    logic                  tap_c_end;
    logic                  tap_r_end;
    logic                  pool_c_end;
    logic                  pool_r_end;
    // scan address terms
    logic [IMG_ADDR_W-1:0] img_base;
    logic [IMG_ADDR_W-1:0] img_row;
    logic [IMG_ADDR_W-1:0] img_col;

    assign side_log = 4'(MIN_SIDE_LOG) + 4'(size_code);
    // 16 images of side x side bytes
    assign img_end  = IMG_ADDR_W'((NUM_MATS << (2 * side_log)) - 1);
    // P = side / 2 - 2
    assign p_max    = 4'((32'd1 << (side_log - 4'd1)) - 32'd3);

    // ##############################
    // load side
    // ##############################
    assign img_we        = load_img && in_valid;
    assign ker_we        = load_ker && in_valid;
    assign load_img_last = img_we && (img_wr_addr == img_end);
    assign load_ker_last = ker_we && (ker_wr_addr == KER_ADDR_W'(KER_DEPTH - 1));

    // wrap to zero at the end, ready for the next load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            img_wr_addr <= '0;
            ker_wr_addr <= '0;
        end else begin
            if (img_we) begin
                img_wr_addr <= load_img_last ? '0 : img_wr_addr + 1'b1;
            end
            if (ker_we) begin
                ker_wr_addr <= load_ker_last ? '0 : ker_wr_addr + 1'b1;
            end
        end
    end

    // ##############################
    // scan walk
    // ##############################
    assign tap_c_end  = (tap_c == 3'(KER_DIM - 1));
    assign tap_r_end  = (tap_r == 3'(KER_DIM - 1));
    assign pool_c_end = (pool_c == p_max);
    assign pool_r_end = (pool_r == p_max);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tap_c  <= '0;
            tap_r  <= '0;
            quad   <= '0;
            pool_c <= '0;
            pool_r <= '0;
        end else if (scan_start) begin
            tap_c  <= '0;
            tap_r  <= '0;
            quad   <= '0;
            pool_c <= '0;
            pool_r <= '0;
        end else if (scan_en) begin
            tap_c <= tap_c_end ? '0 : tap_c + 1'b1;
            if (tap_c_end) begin
                tap_r <= tap_r_end ? '0 : tap_r + 1'b1;
            end
            // window done, next quadrant
            if (tap_c_end && tap_r_end) begin
                quad <= quad + 1'b1;
                // four quadrants done, next pooled position
                if (quad == 2'd3) begin
                    pool_c <= pool_c_end ? '0 : pool_c + 1'b1;
                    if (pool_c_end) begin
                        pool_r <= pool_r_end ? '0 : pool_r + 1'b1;
                    end
                end
            end
        end
    end

    // quadrant bit 1 is the row, bit 0 the column
    assign img_base = IMG_ADDR_W'(img_idx) << (2 * side_log);
    assign img_row  = IMG_ADDR_W'({pool_r, 1'b0}) + IMG_ADDR_W'(quad[1]) + IMG_ADDR_W'(tap_r);
    assign img_col  = IMG_ADDR_W'({pool_c, 1'b0}) + IMG_ADDR_W'(quad[0]) + IMG_ADDR_W'(tap_c);

    // write counters outside the scan
    assign img_addr = scan_en ? img_base + (img_row << side_log) + img_col : img_wr_addr;
    assign ker_addr = scan_en ?
        KER_ADDR_W'(ker_idx) * KER_ADDR_W'(KER_TAPS) +
        KER_ADDR_W'(tap_r) * KER_ADDR_W'(KER_DIM) + KER_ADDR_W'(tap_c) : ker_wr_addr;

    // flags mark the issue cycle
    assign tap_first = scan_en && (tap_c == '0) && (tap_r == '0);
    assign tap_last  = scan_en && tap_c_end && tap_r_end;
    assign scan_done = tap_last && (quad == 2'd3) && pool_c_end && pool_r_end;

endmodule

`default_nettype wire

// File: source/cad_ctrl.sv
`default_nettype none

module cad_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  logic                       in_valid2,
    input  logic [cad_pkg::SIZE_W-1:0] matrix_size,
    input  logic [cad_pkg::IDX_W-1:0]  matrix_idx,
    input  logic                       load_img_last,
    input  logic                       load_ker_last,
    input  logic                       scan_done,
    input  logic                       out_valid,
    output logic                       load_img,
    output logic                       load_ker,
    output logic                       scan_start,
    output logic                       scan_en,
    output logic [cad_pkg::SIZE_W-1:0] size_code,
    output logic [cad_pkg::IDX_W-1:0]  img_idx,
    output logic [cad_pkg::IDX_W-1:0]  ker_idx
);

    import cad_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    // first byte of a load, seen while idle or waiting
    logic        load_begin;
    // out_valid history for the drain exit
    logic        out_valid_q;
    logic        out_fall;

    assign load_begin = in_valid && (state == IDLE || state == WAIT_IDX);
    assign out_fall   = out_valid_q && !out_valid;

    // ##############################
    // phase register
    // ##############################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (in_valid) begin
                    state_nxt = LOAD_IMG;
                end
            end
            // image bytes until the last write address
            LOAD_IMG: begin
                if (load_img_last) begin
                    state_nxt = LOAD_KER;
                end
            end
            // then 400 kernel bytes
            LOAD_KER: begin
                if (load_ker_last) begin
                    state_nxt = WAIT_IDX;
                end
            end
            // a new load wins over a request
            WAIT_IDX: begin
                if (in_valid) begin
                    state_nxt = LOAD_IMG;
                end else if (in_valid2) begin
                    state_nxt = IDX_KER;
                end
            end
            // second request cycle carries the kernel index
            IDX_KER: begin
                state_nxt = SCAN;
            end
            SCAN: begin
                if (scan_done) begin
                    state_nxt = DRAIN;
                end
            end
            // last word leaves the serializer
            DRAIN: begin
                if (out_fall) begin
                    state_nxt = WAIT_IDX;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // ##############################
    // captured size and indices
    // ##############################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            size_code   <= '0;
            img_idx     <= '0;
            ker_idx     <= '0;
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= out_valid;
            // size is sampled on the first load byte only
            if (load_begin) begin
                size_code <= matrix_size;
            end
            if (state == WAIT_IDX && in_valid2 && !in_valid) begin
                img_idx <= matrix_idx;
            end
            if (state == IDX_KER) begin
                ker_idx <= matrix_idx;
            end
        end
    end

    // first image byte is written in the cycle it arrives
    assign load_img   = load_begin || (state == LOAD_IMG);
    assign load_ker   = (state == LOAD_KER);
    // counters clear here, indices are stable from the next cycle
    assign scan_start = (state == IDX_KER);
    assign scan_en    = (state == SCAN);

endmodule

`default_nettype wire

// File: source/mat_sram.sv
`default_nettype none

module mat_sram #(
    parameter int DEPTH = cad_pkg::IMG_DEPTH,
    parameter int ADDR_W = cad_pkg::IMG_ADDR_W,
    parameter int DATA_W = cad_pkg::DATA_W
) (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0] rdata
);

    // storage array, contents undefined until loaded
    logic [DATA_W-1:0] mem [DEPTH];

    // single port
    // write on we, read returns old data one cycle later
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: source/cad_pkg.sv
`default_nettype none

package cad_pkg;

    // ##############################
    // element and sum widths
    // ##############################
    // signed image and kernel bytes
    localparam int DATA_W = 8;
    // 25 products of 16 bits, sign included
    localparam int ACC_W = 20;

    // ##############################
    // dimensions
    // ##############################
    localparam int KER_DIM = 5;
    localparam int KER_TAPS = KER_DIM * KER_DIM;
    // images per load, kernels per load
    localparam int NUM_MATS = 16;
    localparam int IDX_W = 4;
    localparam int SIZE_W = 2;
    // smallest side is 8, side = 8 << size code
    localparam int MIN_SIDE_LOG = 3;

    // 16 images of up to 32 x 32
    localparam int IMG_DEPTH = 16384;
    localparam int IMG_ADDR_W = 14;
    // 16 kernels of 25 taps
    localparam int KER_DEPTH = 400;
    localparam int KER_ADDR_W = 9;

    // ##############################
    // controller phases
    // ##############################
    typedef enum logic [2:0] {
        IDLE,
        LOAD_IMG,
        LOAD_KER,
        WAIT_IDX,
        IDX_KER,
        SCAN,
        DRAIN
    } ctrl_state_t;

endpackage

`default_nettype wire
